/* sources.f */
hdl/clct_pkg.sv
hdl/cc_lut_rom.sv
hdl/lut_arbiter.sv
hdl/group_pattern_finder.sv
hdl/best_1of5_cc.sv
hdl/clct_event_ctrl.sv
hdl/clct_top.sv
tests/clct_assertions.sv
tests/clct_checker.sv
tests/clct_tb.sv

/* Makefile */
# Verilator build and run of the CLCT pattern finder testbench

.PHONY: all run lint clean

all: run

obj_dir/Vclct_tb: sources.f hdl/*.sv tests/*.sv
	verilator --binary --timing --assert -Wno-fatal -f sources.f \
		--top-module clct_tb -o Vclct_tb

# the run passes only if the log holds the pass message
run: obj_dir/Vclct_tb
	rm -f sim.log
	./obj_dir/Vclct_tb | tee sim.log
	grep -q "TESTBENCH PASSED" sim.log

lint:
	verilator --lint-only --timing -Wall -f sources.f --top-module clct_tb

clean:
	rm -rf obj_dir sim.log

/* tests/clct_tb.sv */
`timescale 1ns/1ps
`default_nettype none

module clct_tb;

  import clct_pkg::*;

  localparam int hit_thresh = 4;
  localparam int max_wait   = 40;

  logic       clock;
  logic       rst;
  logic       hit_vld;
  hit_frame_t hits;
  logic       busy;
  logic       clct_vld;
  clct_t      clct;
  string      test_name;
  int         pass_cnt;
  int         fail_cnt;
  int         timeout_cnt;
  int         sent_cnt;

  initial clock = 1'b0;
  always #20 clock = ~clock;

  clct_top #(
    .hit_thresh (hit_thresh)
  ) clct_top_inst (
    .clock    (clock),
    .rst      (rst),
    .hit_vld  (hit_vld),
    .hits     (hits),
    .busy     (busy),
    .clct_vld (clct_vld),
    .clct     (clct)
  );

  clct_checker #(
    .hit_thresh (hit_thresh)
  ) clct_checker_inst (
    .clock     (clock),
    .rst       (rst),
    .test_name (test_name),
    .hit_vld   (hit_vld),
    .hits      (hits),
    .busy      (busy),
    .clct_vld  (clct_vld),
    .clct      (clct),
    .pass_cnt  (pass_cnt),
    .fail_cnt  (fail_cnt)
  );

  // ------------------------------------------------------------
  // frame builders
  // ------------------------------------------------------------
  // track through key for id 2 straight, 1 left or 0 right with layer skip left empty
  function automatic hit_frame_t make_track(int key, int id, int skip);
    hit_frame_t f;
    int         d;
    int         hs;
    f = '0;
    for (int l = 0; l < num_layers; l++)
    begin
      d = (l < 2) ? -1 : ((l > 3) ? 1 : 0);
      if (id == 0)
        d = -d;
      else if (id == 2)
        d = 0;
      hs = key + d;
      if (l != skip && hs >= 0 && hs < num_hs)
        f[l][hs] = 1'b1;
    end
    return f;
  endfunction

  // about one hit in twenty plus a track in half of the frames
  function automatic hit_frame_t random_frame();
    hit_frame_t f;
    f = '0;
    for (int l = 0; l < num_layers; l++)
      for (int hs = 0; hs < num_hs; hs++)
        if ($urandom_range(0, 19) == 0)
          f[l][hs] = 1'b1;
    if ($urandom_range(0, 1) == 1)
      f = f | make_track($urandom_range(0, 39), $urandom_range(0, 2), $urandom_range(0, 7));
    return f;
  endfunction

  // ------------------------------------------------------------
  // waits and stimulus
  // ------------------------------------------------------------
  task automatic wait_idle();
    int n;
    n = 0;
    while (busy && n < max_wait)
    begin
      @(posedge clock);
      #2;
      n++;
    end
    if (busy)
    begin
      $display("timeout: busy still high after %0d cycles before %s", max_wait, test_name);
      timeout_cnt++;
    end
  endtask

  task automatic wait_clct();
    int n;
    n = 0;
    while (!clct_vld && n < max_wait)
    begin
      @(posedge clock);
      #2;
      n++;
    end
    if (!clct_vld)
    begin
      $display("timeout: no clct_vld for %s within %0d cycles", test_name, max_wait);
      timeout_cnt++;
    end
  endtask

  // one-cycle strobe with the frame
  task automatic send_frame(string name, hit_frame_t f);
    @(posedge clock);
    #2;
    test_name = name;
    hits      = f;
    hit_vld   = 1'b1;
    sent_cnt++;
    @(posedge clock);
    #2;
    hit_vld = 1'b0;
  endtask

  task automatic run_test(string name, hit_frame_t f);
    wait_idle();
    send_frame(name, f);
    wait_clct();
  endtask

  // strobes during busy are dropped so only the first frame reports
  task automatic busy_drop_test();
    wait_idle();
    send_frame("busy_drop", make_track(13, 2, 7));
    for (int i = 0; i < 6; i++)
    begin
      @(posedge clock);
      #2;
      hits    = make_track(30, 1, 7);
      hit_vld = (i % 2 == 0);
    end
    hit_vld = 1'b0;
    wait_clct();
    // quiet window where an extra clct_vld would show up
    for (int i = 0; i < 30; i++)
      @(posedge clock);
  endtask

  // ------------------------------------------------------------
  // test sequence
  // ------------------------------------------------------------
  initial
  begin
    hit_frame_t f;
    hit_vld     = 1'b0;
    hits        = '0;
    rst         = 1'b1;
    test_name   = "reset";
    timeout_cnt = 0;
    sent_cnt    = 0;
    void'($urandom(52212));
    for (int i = 0; i < 16; i++)
      @(posedge clock);
    #2;
    rst = 1'b0;

    run_test("straight_hs13", make_track(13, 2, 7));
    // six-hit left in group 3 against five-hit straight in group 0
    run_test("left6_vs_straight5", make_track(28, 1, 7) | make_track(4, 2, 0));
    // six-hit left in group 0 against six-hit straight in group 3
    run_test("straight_vs_left_tie", make_track(4, 1, 7) | make_track(28, 2, 7));
    f       = '0;
    f[0][5] = 1'b1;
    f[1][20] = 1'b1;
    f[3][35] = 1'b1;
    run_test("below_thresh", f);
    run_test("groups_2_4_tie", make_track(20, 2, 7) | make_track(36, 2, 7));
    // left track at the chamber edge wraps the extended key to 63
    run_test("key_wrap_hs0", make_track(0, 1, 7));
    for (int i = 0; i < 40; i++)
      run_test($sformatf("random_%02d", i), random_frame());
    busy_drop_test();

    $display("summary: %0d of %0d tests passed, %0d failed, %0d timeouts",
             pass_cnt, sent_cnt, fail_cnt, timeout_cnt);
    if (fail_cnt == 0 && timeout_cnt == 0 && pass_cnt == sent_cnt)
      $display("TESTBENCH PASSED");
    else
      $display("TESTBENCH FAILED");
    $finish;
  end

endmodule

`default_nettype wire

/* tests/clct_checker.sv */
`timescale 1ns/1ps
`default_nettype none

module clct_checker #(
  parameter int hit_thresh = 4
) (
  input  logic                  clock,
  input  logic                  rst,
  input  string                 test_name,
  input  logic                  hit_vld,
  input  clct_pkg::hit_frame_t  hits,
  input  logic                  busy,
  input  logic                  clct_vld,
  input  clct_pkg::clct_t       clct,
  output int                    pass_cnt,
  output int                    fail_cnt
);

  import clct_pkg::*;

  // expected results of accepted frames, oldest first
  clct_t exp_q[$];
  string name_q[$];
  clct_t exp_clct;
  string exp_name;

  // half-strip lean per layer for id 2 straight, 1 left and 0 right
  function automatic int lean(int id, int layer);
    int left_tab [6];
    left_tab = '{-1, -1, 0, 0, 1, 1};
    if (id == 2)
      return 0;
    else if (id == 1)
      return left_tab[layer];
    else
      return -left_tab[layer];
  endfunction

  // ------------------------------------------------------------
  // reference model of finders, table and selection
  // ------------------------------------------------------------
  function automatic clct_t ref_clct(hit_frame_t f);
    clct_t      r;
    logic [4:0] g_code [num_groups];
    int         g_key [num_groups];
    logic [5:0] g_mask [num_groups];
    logic [4:0] code;
    logic [5:0] m;
    int         hs;
    int         id;
    int         win;
    int         offs;
    int         ekey;
    r   = '0;
    win = -1;
    for (int g = 0; g < num_groups; g++)
    begin
      g_code[g] = '0;
      g_key[g]  = 0;
      g_mask[g] = '0;
      for (int k = 0; k < group_keys; k++)
      begin
        // straight, left, right
        for (int p = 0; p < 3; p++)
        begin
          id = 2 - p;
          m  = '0;
          for (int l = 0; l < num_layers; l++)
          begin
            hs = g * group_keys + k + lean(id, l);
            if (hs >= 0 && hs < num_hs)
              m[l] = f[l][hs];
          end
          code = {3'($countones(m)), 2'(id)};
          if (code > g_code[g])
          begin
            g_code[g] = code;
            g_key[g]  = k;
            g_mask[g] = m;
          end
        end
      end
      // valid groups compete on the code without its lsb
      if (int'(g_code[g][4:2]) >= hit_thresh)
        if (win < 0 || g_code[g][4:1] > g_code[win][4:1])
          win = g;
    end
    if (win < 0)
    begin
      r.bsy = 1'b1;
      return r;
    end
    m    = g_mask[win];
    id   = int'(g_code[win][1:0]);
    offs = id * 4 + int'(m[0]) * 2 + int'(m[5]);
    ekey = win * 8 + g_key[win] + offs / 4 + ((offs >> 1) & offs & 1) - 2;
    ekey = (ekey + 64) % 64;
    r.pat    = g_code[win];
    r.key    = 6'(ekey);
    r.bend   = 4'(id * 4 + int'(m[0] ^ m[5]) * 2 + int'(m[2] ^ m[3]));
    r.carry  = m;
    r.subkey = 8'(ekey * 4 + (offs % 4 + 1) % 4);
    r.qlt    = 6'(int'(g_code[win][4:2]) * 8 + ((id == 2) ? 4 : 0) + int'(m[2]) + int'(m[3]));
    return r;
  endfunction

  // ------------------------------------------------------------
  // capture and compare mid-cycle where all signals are settled
  // ------------------------------------------------------------
  always @(negedge clock)
  begin
    if (rst)
    begin
      pass_cnt = 0;
      fail_cnt = 0;
    end
    else
    begin
      // busy covers an accepted frame up to its clct_vld
      if (exp_q.size() != 0 && !busy && !clct_vld)
      begin
        $display("ERROR: busy dropped while an accepted frame was still in flight");
        fail_cnt = fail_cnt + 1;
      end
      if (exp_q.size() == 0 && busy)
      begin
        $display("ERROR: busy high while no accepted frame was in flight");
        fail_cnt = fail_cnt + 1;
      end
      // frame taken by the DUT only when it is idle
      if (hit_vld && !busy)
      begin
        exp_q.push_back(ref_clct(hits));
        name_q.push_back(test_name);
      end
      if (clct_vld)
      begin
        if (exp_q.size() == 0)
        begin
          $display("ERROR: clct_vld pulsed while no accepted frame was pending");
          fail_cnt = fail_cnt + 1;
        end
        else
        begin
          exp_clct = exp_q.pop_front();
          exp_name = name_q.pop_front();
          if (clct !== exp_clct)
          begin
            $display("FAILED %s expected %h actual %h", exp_name, exp_clct, clct);
            fail_cnt = fail_cnt + 1;
          end
          else
          begin
            $display("ok     %s clct %h", exp_name, clct);
            pass_cnt = pass_cnt + 1;
          end
        end
      end
    end
  end

endmodule

`default_nettype wire

/* tests/clct_assertions.sv */
`timescale 1ns/1ps
`default_nettype none

module clct_assertions (
  input logic                            clock,
  input logic                            rst,
  input logic [clct_pkg::num_groups-1:0] req,
  input logic [clct_pkg::num_groups-1:0] rsp_vld
);

  import clct_pkg::*;

  // cycles each requester has held req without data
  logic [2:0] wait_cnt [num_groups];

  always_ff @(posedge clock)
  begin
    for (int i = 0; i < num_groups; i++)
    begin
      if (rst)
        wait_cnt[i] <= '0;
      else if (!req[i] || rsp_vld[i])
        wait_cnt[i] <= '0;
      else
        wait_cnt[i] <= wait_cnt[i] + 3'd1;
    end
  end

  // ------------------------------------------------------------
  // response rules
  // ------------------------------------------------------------
  rsp_onehot: assert property (@(posedge clock) disable iff (rst) $onehot0(rsp_vld))
    else $error("rsp_vld has more than one bit set");

  // data only goes to a finder that asked the cycle before
  rsp_after_req: assert property (@(posedge clock) disable iff (rst)
                                  (rsp_vld & ~$past(req)) == '0)
    else $error("rsp_vld without a request in the previous cycle");

  for (genvar g = 0; g < num_groups; g++)
  begin : gen_wait
    req_wait: assert property (@(posedge clock) disable iff (rst) wait_cnt[g] <= 3'd5)
      else $error("request %0d waited more than 5 cycles", g);
  end

endmodule

bind lut_arbiter clct_assertions clct_assertions_inst (
  .clock   (clock),
  .rst     (rst),
  .req     (req),
  .rsp_vld (rsp_vld)
);

`default_nettype wire

/* hdl/clct_top.sv */
`timescale 1ns/1ps
`default_nettype none

module clct_top #(
  parameter int hit_thresh = 4
) (
  input  logic                  clock,
  input  logic                  rst,
  input  logic                  hit_vld,
  input  clct_pkg::hit_frame_t  hits,
  output logic                  busy,
  output logic                  clct_vld,
  output clct_pkg::clct_t       clct
);

  import clct_pkg::*;

  logic                                start;
  hit_frame_t                          frame;
  logic [num_groups-1:0]               done;
  logic [num_groups-1:0]               req;
  logic [num_groups-1:0]               rsp_vld;
  lut_addr_t [num_groups-1:0]          lut_addr;
  lut_entry_t                          rsp_data;
  group_cand_t [num_groups-1:0]        cand;
  clct_t                               best;

  clct_event_ctrl clct_event_ctrl_inst (
    .clock    (clock),
    .rst      (rst),
    .hit_vld  (hit_vld),
    .hits     (hits),
    .done     (done),
    .best     (best),
    .start    (start),
    .frame    (frame),
    .busy     (busy),
    .clct_vld (clct_vld),
    .clct     (clct)
  );

  // ------------------------------------------------------------
  // five finders share the table through the arbiter
  // ------------------------------------------------------------
  for (genvar g = 0; g < num_groups; g++)
  begin : gen_finder
    group_pattern_finder #(
      .hit_thresh (hit_thresh)
    ) group_pattern_finder_inst (
      .clock     (clock),
      .rst       (rst),
      .group_idx (3'(g)),
      .start     (start),
      .frame     (frame),
      .req       (req[g]),
      .lut_addr  (lut_addr[g]),
      .rsp_vld   (rsp_vld[g]),
      .rsp_data  (rsp_data),
      .done      (done[g]),
      .cand      (cand[g])
    );
  end

  lut_arbiter lut_arbiter_inst (
    .clock    (clock),
    .rst      (rst),
    .req      (req),
    .addr     (lut_addr),
    .rsp_vld  (rsp_vld),
    .rsp_data (rsp_data)
  );

  best_1of5_cc best_1of5_cc_inst (
    .cand (cand),
    .best (best)
  );

endmodule

`default_nettype wire

/* hdl/clct_event_ctrl.sv */
`timescale 1ns/1ps
`default_nettype none

module clct_event_ctrl (
  input  logic                             clock,
  input  logic                             rst,
  input  logic                             hit_vld,
  input  clct_pkg::hit_frame_t             hits,
  input  logic [clct_pkg::num_groups-1:0]  done,
  input  clct_pkg::clct_t                  best,
  output logic                             start,
  output clct_pkg::hit_frame_t             frame,
  output logic                             busy,
  output logic                             clct_vld,
  output clct_pkg::clct_t                  clct
);

  import clct_pkg::*;

  ctrl_state_e           state;
  logic [num_groups-1:0] done_mask;
  logic [num_groups-1:0] done_all;

  // sticky done bits plus this cycle's pulses
  assign done_all = done_mask | done;

  // ------------------------------------------------------------
  // event FSM
  // ------------------------------------------------------------
  always_ff @(posedge clock)
  begin
    if (rst)
    begin
      state     <= ctrl_idle;
      start     <= 1'b0;
      done_mask <= '0;
      clct      <= '0;
    end
    else
    begin
      start <= 1'b0;
      case (state)
        ctrl_idle:
          // strobes outside idle are dropped
          if (hit_vld)
          begin
            state     <= ctrl_run;
            start     <= 1'b1;
            done_mask <= '0;
          end
        ctrl_run:
        begin
          done_mask <= done_all;
          if (&done_all)
          begin
            clct  <= best;
            state <= ctrl_emit;
          end
        end
        default:
          state <= ctrl_idle;
      endcase
    end
  end

  // frame held for the whole event
  always_ff @(posedge clock)
  begin
    if (state == ctrl_idle && hit_vld)
      frame <= hits;
  end

  assign busy     = (state != ctrl_idle);
  assign clct_vld = (state == ctrl_emit);

endmodule

`default_nettype wire

/* hdl/best_1of5_cc.sv */
`timescale 1ns/1ps
`default_nettype none

module best_1of5_cc (
  input  clct_pkg::group_cand_t [clct_pkg::num_groups-1:0] cand,
  output clct_pkg::clct_t                                  best
);

  import clct_pkg::*;

  logic        sel_found;
  logic [2:0]  sel_idx;
  logic [3:0]  sel_sort;
  group_cand_t win;
  logic [5:0]  ext_key;

  // sort on pat code with the bend lsb dropped
  function automatic logic [3:0] sort_val(group_cand_t c);
    logic [4:0] code;
    code = c.pat;
    return code[4:1];
  endfunction

  // ------------------------------------------------------------
  // pick the winning group
  // ------------------------------------------------------------
  always_comb
  begin
    sel_found = 1'b0;
    sel_idx   = '0;
    sel_sort  = '0;
    for (int g = 0; g < num_groups; g++)
    begin
      // groups without a candidate are skipped
      // strict compare keeps the lower group on a tie
      if (cand[g].vld && (!sel_found || sort_val(cand[g]) > sel_sort))
      begin
        sel_found = 1'b1;
        sel_idx   = 3'(g);
        sel_sort  = sort_val(cand[g]);
      end
    end
  end

  assign win = cand[sel_idx];

  // extended key from group, key and table offset, wraps at 64
  assign ext_key = {sel_idx, win.key} + 6'(win.lut.offs[3:2])
                 + 6'(win.lut.offs[1] & win.lut.offs[0]) - 6'd2;

  // ------------------------------------------------------------
  // output fields
  // ------------------------------------------------------------
  always_comb
  begin
    best = '0;
    if (sel_found)
    begin
      best.pat    = win.pat;
      best.key    = ext_key;
      best.bend   = win.lut.bend;
      best.carry  = win.carry;
      // quarter-strip position below the key
      best.subkey = {ext_key, 2'(win.lut.offs[1:0] + 2'd1)};
      best.qlt    = win.lut.qlt;
    end
    else
      best.bsy = 1'b1;
  end

endmodule

`default_nettype wire

/* hdl/group_pattern_finder.sv */
`timescale 1ns/1ps
`default_nettype none

module group_pattern_finder #(
  parameter int hit_thresh = 4
) (
  input  logic                   clock,
  input  logic                   rst,
  input  logic [2:0]             group_idx,
  input  logic                   start,
  input  clct_pkg::hit_frame_t   frame,
  output logic                   req,
  output clct_pkg::lut_addr_t    lut_addr,
  input  logic                   rsp_vld,
  input  clct_pkg::lut_entry_t   rsp_data,
  output logic                   done,
  output clct_pkg::group_cand_t  cand
);

  import clct_pkg::*;

  finder_state_e state;
  logic [2:0]    key_cnt;
  // running best over the keys scanned so far
  pat_code_t     best_pat;
  logic [2:0]    best_key;
  logic [5:0]    best_mask;
  // best including the key of this cycle
  pat_code_t     scan_pat;
  logic [2:0]    scan_key;
  logic [5:0]    scan_mask;

  // layer mask of one pattern around one key, off-chamber counts as empty
  function automatic logic [5:0] layer_mask(hit_frame_t f, int key, pattern_id_e id);
    logic [5:0] m;
    int hs;
    m = '0;
    for (int l = 0; l < num_layers; l++)
    begin
      hs = key + hs_offset(id, l);
      if (hs >= 0 && hs < num_hs)
        m[l] = f[l][hs];
    end
    return m;
  endfunction

  // ------------------------------------------------------------
  // one key per cycle, straight then left then right
  // ------------------------------------------------------------
  always_comb
  begin
    int          key_hs;
    pattern_id_e id;
    logic [5:0]  m;
    pat_code_t   code;
    key_hs    = int'(group_idx) * group_keys + int'(key_cnt);
    scan_pat  = best_pat;
    scan_key  = best_key;
    scan_mask = best_mask;
    for (int p = 0; p < 3; p++)
    begin
      id         = (p == 0) ? pat_straight : ((p == 1) ? pat_left : pat_right);
      m          = layer_mask(frame, key_hs, id);
      code.nhits = 3'($countones(m));
      code.id    = id;
      // strict compare, an earlier key keeps a tie
      if (code > scan_pat)
      begin
        scan_pat  = code;
        scan_key  = key_cnt;
        scan_mask = m;
      end
    end
  end

  // ------------------------------------------------------------
  // control FSM
  // ------------------------------------------------------------
  always_ff @(posedge clock)
  begin
    if (rst)
    begin
      state   <= find_idle;
      key_cnt <= '0;
    end
    else
    begin
      case (state)
        find_idle:
          if (start)
          begin
            state   <= find_scan;
            key_cnt <= '0;
          end
        find_scan:
        begin
          key_cnt <= key_cnt + 3'd1;
          if (key_cnt == 3'(group_keys - 1))
          begin
            // weak candidates skip the table
            if (int'(scan_pat.nhits) >= hit_thresh)
              state <= find_lookup;
            else
              state <= find_done;
          end
        end
        find_lookup:
          if (rsp_vld)
            state <= find_done;
        default:
          state <= find_idle;
      endcase
    end
  end

  // candidate payload
  always_ff @(posedge clock)
  begin
    if (state == find_idle && start)
      best_pat <= '0;
    else if (state == find_scan)
    begin
      best_pat  <= scan_pat;
      best_key  <= scan_key;
      best_mask <= scan_mask;
    end
    if (state == find_scan && key_cnt == 3'(group_keys - 1)
        && int'(scan_pat.nhits) < hit_thresh)
      cand <= '0;
    else if (state == find_lookup && rsp_vld)
      cand <= '{vld: 1'b1, pat: best_pat, key: best_key, carry: best_mask, lut: rsp_data};
  end

  // req held through the whole lookup until data returns
  assign req           = (state == find_lookup);
  assign lut_addr.id   = best_pat.id;
  assign lut_addr.mask = best_mask;
  assign done          = (state == find_done);

endmodule

`default_nettype wire

/* hdl/lut_arbiter.sv */
`timescale 1ns/1ps
`default_nettype none

module lut_arbiter (
  input  logic                                               clock,
  input  logic                                               rst,
  input  logic [clct_pkg::num_groups-1:0]                    req,
  input  clct_pkg::lut_addr_t [clct_pkg::num_groups-1:0]     addr,
  output logic [clct_pkg::num_groups-1:0]                    rsp_vld,
  output clct_pkg::lut_entry_t                               rsp_data
);

  import clct_pkg::*;

  localparam int idx_w = $clog2(num_groups);

  logic [idx_w-1:0]      last_grant;
  logic [idx_w-1:0]      grant_idx;
  logic [num_groups-1:0] eligible;
  logic [num_groups-1:0] grant;
  lut_addr_t             rom_addr;

  // a requester whose data is returning this cycle still holds req
  // keep it out so it is not granted twice
  assign eligible = req & ~rsp_vld;

  // ------------------------------------------------------------
  // round robin, search starts one past the last grant
  // ------------------------------------------------------------
  always_comb
  begin
    int idx;
    grant     = '0;
    grant_idx = last_grant;
    for (int i = 1; i <= num_groups; i++)
    begin
      idx = (int'(last_grant) + i) % num_groups;
      if (grant == '0 && eligible[idx])
      begin
        grant[idx] = 1'b1;
        grant_idx  = idx_w'(idx);
      end
    end
  end

  // granted address goes straight to the ROM
  assign rom_addr = addr[grant_idx];

  always_ff @(posedge clock)
  begin
    if (rst)
    begin
      // first search then starts at group 0
      last_grant <= idx_w'(num_groups - 1);
      rsp_vld    <= '0;
    end
    else
    begin
      if (grant != '0)
        last_grant <= grant_idx;
      // ROM data lands together with the delayed grant
      rsp_vld <= grant;
    end
  end

  cc_lut_rom cc_lut_rom_inst (
    .clock (clock),
    .addr  (rom_addr),
    .data  (rsp_data)
  );

endmodule

`default_nettype wire

/* hdl/cc_lut_rom.sv */
`timescale 1ns/1ps
`default_nettype none

module cc_lut_rom (
  input  logic                  clock,
  input  clct_pkg::lut_addr_t   addr,
  output clct_pkg::lut_entry_t  data
);

  import clct_pkg::*;

  // whole table as one packed constant, entry n at address n
  typedef lut_entry_t [255:0] rom_t;

  // ------------------------------------------------------------
  // table build at elaboration
  // ------------------------------------------------------------
  function automatic rom_t build_rom();
    rom_t t;
    for (int i = 0; i < 256; i++)
    begin
      // addresses with id 3 still get an entry, never requested
      t[i] = lut_rule(lut_addr_t'(8'(i)));
    end
    return t;
  endfunction

  localparam rom_t rom_table = build_rom();

  // ------------------------------------------------------------
  // registered read, one cycle
  // ------------------------------------------------------------
  always_ff @(posedge clock)
  begin
    data <= rom_table[addr];
  end

endmodule

`default_nettype wire

/* hdl/clct_pkg.sv */
`default_nettype none

package clct_pkg;

  // ------------------------------------------------------------
  // frame geometry
  // ------------------------------------------------------------
  localparam int num_layers = 6;
  localparam int num_groups = 5;
  localparam int group_keys = 8;
  localparam int num_hs     = 40;

  // one half-strip vector per layer, layer 0 in the low bits
  typedef logic [num_layers-1:0][num_hs-1:0] hit_frame_t;

  // lsb of the id is the bend direction
  typedef enum logic [1:0] {
    pat_right    = 2'd0,
    pat_left     = 2'd1,
    pat_straight = 2'd2
  } pattern_id_e;

  // sort value is nhits plus id msb, bend lsb dropped
  typedef struct packed {
    logic [2:0]  nhits;
    pattern_id_e id;
  } pat_code_t;

  // table address, pattern id over the layer mask
  typedef struct packed {
    pattern_id_e id;
    logic [5:0]  mask;
  } lut_addr_t;

  typedef struct packed {
    logic [3:0] offs;
    logic [3:0] bend;
    logic [5:0] qlt;
  } lut_entry_t;

  // per-group result, carry holds the layer mask
  typedef struct packed {
    logic       vld;
    pat_code_t  pat;
    logic [2:0] key;
    logic [5:0] carry;
    lut_entry_t lut;
  } group_cand_t;

  typedef struct packed {
    logic [4:0] pat;
    logic [5:0] key;
    logic [3:0] bend;
    logic [5:0] carry;
    logic [7:0] subkey;
    logic [5:0] qlt;
    logic       bsy;
  } clct_t;

  typedef enum logic [1:0] {find_idle, find_scan, find_lookup, find_done} finder_state_e;
  typedef enum logic [1:0] {ctrl_idle, ctrl_run, ctrl_emit} ctrl_state_e;

  // ------------------------------------------------------------
  // pattern shapes and comparator-code table rule
  // ------------------------------------------------------------
  // half-strip offset of a pattern in a given layer
  function automatic int hs_offset(pattern_id_e id, int layer);
    int dir;
    case (id)
      pat_left:  dir = -1;
      pat_right: dir = 1;
      default:   dir = 0;
    endcase
    // outer layers lean, layers 2 and 3 sit on the key
    if (layer < 2)
      return dir;
    else if (layer > 3)
      return -dir;
    else
      return 0;
  endfunction

  function automatic lut_entry_t lut_rule(lut_addr_t a);
    lut_entry_t e;
    logic [2:0] nhits;
    nhits  = 3'($countones(a.mask));
    e.offs = {a.id, a.mask[0], a.mask[5]};
    e.bend = {a.id, a.mask[0] ^ a.mask[5], a.mask[2] ^ a.mask[3]};
    // hit count dominates, straight gets a small bonus
    e.qlt  = 6'(nhits) * 6'd8 + ((a.id == pat_straight) ? 6'd4 : 6'd0)
           + 6'(a.mask[2]) + 6'(a.mask[3]);
    return e;
  endfunction

endpackage

`default_nettype wire
